//--- flist.f
hdl/pmux_pkg.sv
hdl/line_align.sv
hdl/slot_extract.sv
hdl/branch_redirect.sv
hdl/pipeline_mux.sv
tb/pipeline_mux_checker.sv
tb/tb_pipeline_mux.sv

//--- hdl/branch_redirect.sv
// Stage 3: first subroutine call in the group, its target and the registered redirect
`timescale 1ns/1ps

module branch_redirect (
	input  logic                 clk,
	input  logic                 rst_i,
	input  logic                 advance_i,
	input  logic                 stomp_i,
	input  pmux_pkg::group_t     group_i,
	output pmux_pkg::redirect_t  redirect_o
);

	import pmux_pkg::*;

	logic            found;
	logic [PC_W-1:0] tgt;

	// Scan from the top slot down, so the lowest matching slot is kept
	// The disp field is wider than the PC, so sign extension followed by
	// truncation leaves just its low PC_W bits
	always_comb
	begin
		found = 1'b0;
		tgt   = RSTPC;
		for (int i = NSLOTS - 1; i >= 0; i--)
		begin
			if (group_i[i].v)
			begin
				if (group_i[i].ins.br.opcode == OP_BSR)
				begin
					found = 1'b1;
					tgt   = group_i[i].pc + group_i[i].ins.br.disp[PC_W-1:0];
				end
				else if (group_i[i].ins.br.opcode == OP_JSR)
				begin
					found = 1'b1;
					tgt   = group_i[i].ins.br.disp[PC_W-1:0];
				end
			end
		end
	end

	// Target is payload, held with the group it came from
	always_ff @(posedge clk)
	begin
		if (advance_i)
			redirect_o.tgt <= tgt;
	end

	// A stomped group must not steer fetch
	always_ff @(posedge clk)
	begin
		if (rst_i)
			redirect_o.do_bsr <= 1'b0;
		else if (advance_i)
			redirect_o.do_bsr <= found && !stomp_i;
	end

endmodule

//--- hdl/line_align.sv
// Stage 1 of the instruction mux: line alignment, repeat detection and request capture
`timescale 1ns/1ps

module line_align (
	input  logic                          clk,
	input  logic                          rst_i,
	input  logic                          advance_i,
	input  logic [pmux_pkg::LINE_W-1:0]   line_i,
	input  logic [pmux_pkg::PC_W-1:0]     pc_i,
	input  logic [2:0]                    irq_i,
	input  logic                          nmi_i,
	input  logic                          mc_valid_i,
	input  logic                          branchmiss_i,
	input  logic [pmux_pkg::PC_W-1:0]     misspc_i,
	output pmux_pkg::align_t              align_o
);

	import pmux_pkg::*;

	// Line with four NOPs above it, so a shift never pulls in unknown words
	logic [LINE_W+NSLOTS*INS_W-1:0] ext_line;
	logic [LINE_W+NSLOTS*INS_W-1:0] shifted;
	logic [NSLOTS*INS_W-1:0]        win;

	// Last accepted fetch, used to spot a group that repeats
	logic [NSLOTS*INS_W-1:0]        prev_win;
	logic [PC_W-1:0]                prev_pc;
	logic                           prev_valid;
	logic                           redundant;

	// The word index inside the line comes from PC bits 4:2
	// Each step moves the line down by one 32-bit instruction
	always_comb
	begin
		ext_line = {{NSLOTS{NOP_INS}}, line_i};
		shifted  = ext_line >> {pc_i[4:2], 5'd0};
		win      = shifted[NSLOTS*INS_W-1:0];
	end

	// A refetch of the same PC with the same aligned words adds nothing new
	assign redundant = prev_valid && (prev_pc == pc_i) && (prev_win == win);

	always_ff @(posedge clk)
	begin
		if (advance_i)
		begin
			prev_win <= win;
			prev_pc  <= pc_i;
		end
		if (rst_i)
			prev_valid <= 1'b0;
		else if (advance_i)
			prev_valid <= 1'b1;
	end

	// Payload of the stage register
	always_ff @(posedge clk)
	begin
		if (advance_i)
		begin
			align_o.win       <= win;
			align_o.pc        <= pc_i;
			align_o.irq_level <= irq_i;
			align_o.misspc    <= misspc_i;
		end
	end

	// Requests travel with the line they were sampled with
	always_ff @(posedge clk)
	begin
		if (rst_i)
		begin
			align_o.redundant <= 1'b0;
			align_o.irq       <= 1'b0;
			align_o.nmi       <= 1'b0;
			align_o.mcv       <= 1'b0;
			align_o.miss      <= 1'b0;
		end
		else if (advance_i)
		begin
			align_o.redundant <= redundant;
			align_o.irq       <= |irq_i;
			align_o.nmi       <= nmi_i;
			align_o.mcv       <= mc_valid_i;
			align_o.miss      <= branchmiss_i;
		end
	end

endmodule

//--- hdl/pipeline_mux.sv
// Top level of the instruction-group mux: alignment, four slot extractors and call redirect
`timescale 1ns/1ps

module pipeline_mux (
	input  logic                          clk,
	input  logic                          rst_i,
	input  logic                          advance_i,
	input  logic [pmux_pkg::LINE_W-1:0]   line_i,
	input  logic [pmux_pkg::PC_W-1:0]     pc_i,
	input  logic [2:0]                    irq_i,
	input  logic                          nmi_i,
	input  logic                          mc_valid_i,
	input  pmux_pkg::mc_group_t           mc_i,
	input  logic                          branchmiss_i,
	input  logic [pmux_pkg::PC_W-1:0]     misspc_i,
	input  logic                          stomp_i,
	output pmux_pkg::group_t              group_o,
	output pmux_pkg::redirect_t           redirect_o
);

	import pmux_pkg::*;

	// Stage 1 to stage 2
	align_t align;

	// ========================================================================
	// Stage 1, line alignment
	// ========================================================================

	line_align u_align (
		.clk          (clk),
		.rst_i        (rst_i),
		.advance_i    (advance_i),
		.line_i       (line_i),
		.pc_i         (pc_i),
		.irq_i        (irq_i),
		.nmi_i        (nmi_i),
		.mc_valid_i   (mc_valid_i),
		.branchmiss_i (branchmiss_i),
		.misspc_i     (misspc_i),
		.align_o      (align)
	);

	// Stage 2, one extractor per slot, each picking its own window word
	for (genvar g = 0; g < NSLOTS; g++)
	begin : g_slot
		slot_extract #(
			.SLOT (g)
		) u_slot (
			.clk       (clk),
			.rst_i     (rst_i),
			.advance_i (advance_i),
			.align_i   (align),
			.mc_i      (mc_i),
			.slot_o    (group_o[g])
		);
	end

	// Stage 3 looks at the group already presented to decode
	branch_redirect u_redirect (
		.clk        (clk),
		.rst_i      (rst_i),
		.advance_i  (advance_i),
		.stomp_i    (stomp_i),
		.group_i    (group_o),
		.redirect_o (redirect_o)
	);

endmodule

//--- hdl/pmux_pkg.sv
// Front-end widths, opcodes, the instruction word union, slot, group and stage structs

package pmux_pkg;

	// ========================================================================
	// Widths and constants
	// ========================================================================

	// Byte address of an instruction
	localparam int PC_W   = 16;
	localparam int INS_W  = 32;
	// One fetched cache line carries eight instructions
	localparam int LINE_W = 256;
	// Instructions handed to decode per group
	localparam int NSLOTS = 4;

	// Reset vector, also reported as the redirect target when no call is found
	localparam logic [PC_W-1:0] RSTPC = 16'hFFC0;

	localparam logic [6:0] OP_NOP = 7'h0B;
	localparam logic [6:0] OP_BSR = 7'h20;
	localparam logic [6:0] OP_JSR = 7'h21;

	// NOP has every field other than the opcode at zero
	localparam logic [INS_W-1:0] NOP_INS = {{(INS_W-7){1'b0}}, OP_NOP};

	// ========================================================================
	// Instruction word
	// ========================================================================

	// Register format, opcode sits in the low bits of the word
	typedef struct packed {
		logic [9:0] func;
		logic [4:0] rb;
		logic [4:0] ra;
		logic [4:0] rt;
		logic [6:0] opcode;
	} r3_t;

	// Branch format, disp is a signed offset for BSR and an absolute target for JSR
	typedef struct packed {
		logic signed [24:0] disp;
		logic [6:0]         opcode;
	} br_t;

	// Both views overlay the same 32 bits, so the opcode lines up in each
	typedef union packed {
		r3_t r3;
		br_t br;
	} ins_word_u;

	// ========================================================================
	// Slot and group structures
	// ========================================================================

	// One decoded slot as handed on to the decoder
	typedef struct packed {
		logic            v;
		logic            hwi;
		logic [2:0]      hwi_level;
		logic            mc;
		logic [PC_W-1:0] pc;
		ins_word_u       ins;
		logic [4:0]      ra;
		logic [4:0]      rb;
		logic [4:0]      rt;
	} slot_t;

	typedef slot_t [NSLOTS-1:0] group_t;

	// Micro-code ROM output, four words read from one address
	typedef struct packed {
		ins_word_u [NSLOTS-1:0] ins;
		logic [11:0]            adr;
	} mc_group_t;

	// Stage 1 result, the aligned window plus the requests captured with it
	typedef struct packed {
		logic [NSLOTS*INS_W-1:0] win;
		logic [PC_W-1:0]         pc;
		logic                    redundant;
		logic                    irq;
		logic [2:0]              irq_level;
		logic                    nmi;
		logic                    mcv;
		logic                    miss;
		logic [PC_W-1:0]         misspc;
	} align_t;

	// Early subroutine redirect toward fetch
	typedef struct packed {
		logic            do_bsr;
		logic [PC_W-1:0] tgt;
	} redirect_t;

endpackage

//--- hdl/slot_extract.sv
// Stage 2 for one slot: instruction source select, interrupt marking, miss nulling, field extract
`timescale 1ns/1ps

module slot_extract #(
	parameter int SLOT = 0
) (
	input  logic                 clk,
	input  logic                 rst_i,
	input  logic                 advance_i,
	input  pmux_pkg::align_t     align_i,
	input  pmux_pkg::mc_group_t  mc_i,
	output pmux_pkg::slot_t      slot_o
);

	import pmux_pkg::*;

	logic [PC_W-1:0] slot_pc;
	ins_word_u       ins;
	logic            from_mc;
	logic            hwi;
	logic [2:0]      hwi_level;
	logic            nulled;

	// Each slot sits one instruction further along than the one below it
	assign slot_pc = align_i.pc + PC_W'(4 * SLOT);

	// ========================================================================
	// Instruction source
	// ========================================================================

	// Micro-code words come straight from the ROM, which answers one cycle
	// after mc_valid_i was captured, so they line up with this stage
	always_comb
	begin
		from_mc = 1'b0;
		if (align_i.mcv)
		begin
			ins     = mc_i.ins[SLOT];
			from_mc = 1'b1;
		end
		else if (align_i.redundant)
			ins = NOP_INS;
		else
			ins = align_i.win[SLOT*INS_W +: INS_W];
	end

	// ========================================================================
	// Interrupt and branch-miss handling
	// ========================================================================

	// An interrupt takes over the whole group, so every slot is marked
	// NMI is always reported at the top level
	assign hwi       = align_i.irq || align_i.nmi;
	assign hwi_level = align_i.nmi ? 3'd7 : align_i.irq_level;

	// Slots before the miss target were already executed on the old path
	assign nulled = align_i.miss && (align_i.misspc > slot_pc);

	// Payload of the slot register
	always_ff @(posedge clk)
	begin
		if (advance_i)
		begin
			slot_o.hwi_level <= hwi_level;
			slot_o.pc        <= slot_pc;
			slot_o.ins       <= ins;
			// Register fields always come from the r3 view
			slot_o.ra        <= ins.r3.ra;
			slot_o.rb        <= ins.r3.rb;
			slot_o.rt        <= ins.r3.rt;
		end
	end

	// Control bits of the slot
	always_ff @(posedge clk)
	begin
		if (rst_i)
		begin
			slot_o.v   <= 1'b0;
			slot_o.hwi <= 1'b0;
			slot_o.mc  <= 1'b0;
		end
		else if (advance_i)
		begin
			slot_o.v   <= !hwi && !nulled;
			slot_o.hwi <= hwi;
			slot_o.mc  <= from_mc;
		end
	end

endmodule

//--- tb/pipeline_mux_checker.sv
// Concurrent assertions on the instruction mux outputs, bound into the top level
`timescale 1ns/1ps

module pipeline_mux_checker (
	input  logic                 clk,
	input  logic                 rst_i,
	input  logic                 advance_i,
	input  logic                 nmi_i,
	input  logic                 stomp_i,
	input  pmux_pkg::group_t     group_i,
	input  pmux_pkg::redirect_t  redirect_i
);

	import pmux_pkg::*;

	// Read by the testbench when it sums up the run
	int   fail_count = 0;
	logic any_live;
	logic all_nmi;

	// Any slot still valid or flagged, and whether every slot carries an NMI
	always_comb
	begin
		any_live = 1'b0;
		all_nmi  = 1'b1;
		for (int i = 0; i < NSLOTS; i++)
		begin
			any_live = any_live | group_i[i].v | group_i[i].hwi;
			all_nmi  = all_nmi & group_i[i].hwi & !group_i[i].v & (group_i[i].hwi_level == 3'd7);
		end
	end

	// Reset clears the slot control bits and the redirect request
	a_reset_out: assert property (@(posedge clk) rst_i |=> !any_live && !redirect_i.do_bsr)
	else
	begin
		$error("Outputs not cleared after reset");
		fail_count++;
	end

	// An accepted NMI marks the whole group once the next advance moves it out
	a_nmi_group: assert property (@(posedge clk) disable iff (rst_i)
		(advance_i && nmi_i) |=> advance_i[->1] ##1 all_nmi)
	else
	begin
		$error("NMI group does not carry hwi level 7 in every slot");
		fail_count++;
	end

	a_stomp: assert property (@(posedge clk) disable iff (rst_i)
		(advance_i && stomp_i) |=> !redirect_i.do_bsr)
	else
	begin
		$error("Redirect raised for a stomped group");
		fail_count++;
	end

	// Back-pressure, nothing in the group moves on a stalled edge
	a_hold: assert property (@(posedge clk) disable iff (rst_i)
		!advance_i |=> (group_i === $past(group_i)))
	else
	begin
		$error("Group changed while advance was low");
		fail_count++;
	end

endmodule

bind pipeline_mux pipeline_mux_checker u_checker (
	.clk        (clk),
	.rst_i      (rst_i),
	.advance_i  (advance_i),
	.nmi_i      (nmi_i),
	.stomp_i    (stomp_i),
	.group_i    (group_o),
	.redirect_i (redirect_o)
);

//--- tb/tb_pipeline_mux.sv
// Testbench for the instruction-group mux: clock, reset, stimulus, reference model and checks
`timescale 1ns/1ps

module tb_pipeline_mux;

	import pmux_pkg::*;

	// Stimulus runs for about 200 cycles
	localparam int MAX_CYCLES = 400;

	logic                    clk;
	logic                    rst_i;
	logic                    advance_i;
	logic [LINE_W-1:0]       line_i;
	logic [PC_W-1:0]         pc_i;
	logic [2:0]              irq_i;
	logic                    nmi_i;
	logic                    mc_valid_i;
	mc_group_t               mc_i;
	logic                    branchmiss_i;
	logic [PC_W-1:0]         misspc_i;
	logic                    stomp_i;
	group_t                  group_o;
	redirect_t               redirect_o;

	// Model pipeline, one entry per stage, each with a known flag
	group_t                  pend_grp;
	group_t                  exp_grp;
	redirect_t               exp_red;
	logic                    pend_ok;
	logic                    grp_ok;
	logic                    red_ok;
	// Last accepted fetch, for repeat detection
	logic [NSLOTS*INS_W-1:0] prev_win;
	logic [PC_W-1:0]         prev_pc;
	logic                    prev_ok;
	int                      errors = 0;
	int                      cycles = 0;

	pipeline_mux DUT (.*);

	initial clk = 1'b0;
	always #50 clk = ~clk;

	// ========================================================================
	// Reference model
	// ========================================================================

	// Word k of the window is line word pc[4:2]+k, or a NOP past the line end
	function automatic logic [NSLOTS*INS_W-1:0] window_of(logic [LINE_W-1:0] line,
			logic [PC_W-1:0] pc);
		logic [NSLOTS*INS_W-1:0] win;
		int                      w;
		for (int k = 0; k < NSLOTS; k++)
		begin
			w = int'(pc[4:2]) + k;
			win[k*INS_W +: INS_W] = (w < 8) ? line[w*INS_W +: INS_W] : NOP_INS;
		end
		return win;
	endfunction

	function automatic group_t expect_group(logic [NSLOTS*INS_W-1:0] win, logic [PC_W-1:0] pc,
			logic [2:0] irq, logic nmi, logic mcv, logic miss, logic [PC_W-1:0] mpc, logic rep);
		group_t g;
		for (int k = 0; k < NSLOTS; k++)
		begin
			g[k].pc = pc + PC_W'(4 * k);
			// Micro-code beats a repeat, a repeat gives NOPs
			if (mcv)
				g[k].ins = mc_i.ins[k];
			else if (rep)
				g[k].ins = NOP_INS;
			else
				g[k].ins = win[k*INS_W +: INS_W];
			g[k].mc        = mcv;
			g[k].hwi       = (irq != 3'd0) || nmi;
			g[k].hwi_level = nmi ? 3'd7 : irq;
			g[k].v         = !g[k].hwi && !(miss && (mpc > g[k].pc));
			g[k].ra        = g[k].ins.r3.ra;
			g[k].rb        = g[k].ins.r3.rb;
			g[k].rt        = g[k].ins.r3.rt;
		end
		return g;
	endfunction

	// Lowest valid call slot wins, BSR is PC relative and JSR absolute
	function automatic redirect_t expect_redirect(group_t g, logic stomp);
		redirect_t r;
		logic      found;
		found = 1'b0;
		r.tgt = RSTPC;
		for (int k = 0; k < NSLOTS; k++)
		begin
			if (!found && g[k].v && g[k].ins.br.opcode inside {OP_BSR, OP_JSR})
			begin
				found = 1'b1;
				r.tgt = g[k].ins.br.disp[PC_W-1:0];
				if (g[k].ins.br.opcode == OP_BSR)
					r.tgt = r.tgt + g[k].pc;
			end
		end
		r.do_bsr = found && !stomp;
		return r;
	endfunction

	// Every stage moves on the same advance edge as the DUT
	always @(posedge clk)
	begin
		if (rst_i)
		begin
			pend_ok <= 1'b0;
			grp_ok  <= 1'b0;
			red_ok  <= 1'b0;
			prev_ok <= 1'b0;
		end
		else if (advance_i)
		begin
			exp_red  <= expect_redirect(exp_grp, stomp_i);
			red_ok   <= grp_ok;
			exp_grp  <= pend_grp;
			grp_ok   <= pend_ok;
			pend_grp <= expect_group(window_of(line_i, pc_i), pc_i, irq_i, nmi_i, mc_valid_i,
				branchmiss_i, misspc_i,
				prev_ok && (prev_pc == pc_i) && (prev_win == window_of(line_i, pc_i)));
			pend_ok  <= 1'b1;
			prev_win <= window_of(line_i, pc_i);
			prev_pc  <= pc_i;
			prev_ok  <= 1'b1;
		end
	end

	// Outputs are compared half a cycle after the edge, well clear of it
	always @(negedge clk)
	begin
		if (!rst_i && grp_ok)
			assert (group_o === exp_grp)
			else
			begin
				$display("CHECK FAILED at %0t: group_o wrong for pc %h", $time, exp_grp[0].pc);
				errors++;
			end
		if (!rst_i && red_ok)
			assert (redirect_o === exp_red)
			else
			begin
				$display("CHECK FAILED at %0t: redirect_o %h, expected %h", $time, redirect_o,
					exp_red);
				errors++;
			end
	end

	always @(posedge clk)
	begin
		cycles++;
		if (cycles >= MAX_CYCLES)
		begin
			$display("Test timed out after %0d cycles with %0d errors", cycles, errors);
			$display("Checks failed");
			$finish;
		end
	end

	// ========================================================================
	// Stimulus
	// ========================================================================

	function automatic logic [LINE_W-1:0] rand_line();
		logic [LINE_W-1:0] l;
		for (int k = 0; k < 8; k++)
			l[k*INS_W +: INS_W] = $urandom;
		return l;
	endfunction

	// Puts a call with a random disp into slot k of a fetch at pc
	function automatic logic [LINE_W-1:0] with_call(logic [LINE_W-1:0] line,
			logic [PC_W-1:0] pc, int k, logic [6:0] op);
		line[(int'(pc[4:2]) + k)*INS_W +: INS_W] = {25'($urandom), op};
		return line;
	endfunction

	task automatic fetch(input logic [LINE_W-1:0] line, input logic [PC_W-1:0] pc,
			input logic [2:0] irq, input logic nmi, input logic mcv, input logic miss,
			input logic [PC_W-1:0] mpc, input logic stomp);
		advance_i    = 1'b1;
		line_i       = line;
		pc_i         = pc;
		irq_i        = irq;
		nmi_i        = nmi;
		mc_valid_i   = mcv;
		branchmiss_i = miss;
		misspc_i     = mpc;
		stomp_i      = stomp;
		@(posedge clk);
		#1;
	endtask

	// Fetch stalls while the line keeps changing underneath
	task automatic hold(input int n);
		advance_i = 1'b0;
		repeat (n)
		begin
			line_i = rand_line();
			pc_i   = 16'($urandom);
			@(posedge clk);
			#1;
		end
	endtask

	initial
	begin
		logic [LINE_W-1:0] line;
		logic [PC_W-1:0]   pc;
		logic              bsr_first;
		void'($urandom(32'hb2b6de9b));
		rst_i        = 1'b1;
		advance_i    = 1'b0;
		line_i       = '0;
		pc_i         = '0;
		irq_i        = 3'd0;
		nmi_i        = 1'b0;
		mc_valid_i   = 1'b0;
		branchmiss_i = 1'b0;
		misspc_i     = '0;
		stomp_i      = 1'b0;
		// ROM words stay put, since the ROM answers one cycle after the request
		mc_i = {32'($urandom), 32'($urandom), 32'($urandom), 32'($urandom), 12'($urandom)};
		repeat (5) @(posedge clk);
		#1;
		rst_i = 1'b0;

		repeat (100)
			fetch(rand_line(), 16'($urandom) & 16'hFFFC, 3'd0, 1'b0, 1'b0, 1'b0, '0, 1'b0);

		// Same line and PC twice, then a stall
		line = rand_line();
		pc   = 16'($urandom) & 16'hFFFC;
		fetch(line, pc, 3'd0, 1'b0, 1'b0, 1'b0, '0, 1'b0);
		fetch(line, pc, 3'd0, 1'b0, 1'b0, 1'b0, '0, 1'b0);
		hold(6);

		for (int lvl = 1; lvl < 8; lvl++)
			fetch(rand_line(), pc, 3'(lvl), 1'b0, 1'b0, 1'b0, '0, 1'b0);
		fetch(rand_line(), pc, 3'd0, 1'b1, 1'b0, 1'b0, '0, 1'b0);
		fetch(rand_line(), pc, 3'd2, 1'b1, 1'b0, 1'b0, '0, 1'b0);

		repeat (4)
			fetch(rand_line(), pc, 3'd0, 1'b0, 1'b1, 1'b0, '0, 1'b0);

		// Miss target just above slot k nulls slots 0 to k
		repeat (2)
		begin
			pc = 16'($urandom) & 16'h7FFC;
			for (int k = 0; k < NSLOTS; k++)
				fetch(rand_line(), pc, 3'd0, 1'b0, 1'b0, 1'b1, pc + PC_W'(4 * k + 2), 1'b0);
		end

		// A BSR and a JSR in random slots of a NOP line, PC kept so all four fit
		repeat (60)
		begin
			pc        = (16'($urandom) & 16'h7FE0) | PC_W'(($urandom % 5) << 2);
			bsr_first = 1'($urandom);
			line      = with_call({8{NOP_INS}}, pc, $urandom % 4, bsr_first ? OP_JSR : OP_BSR);
			line      = with_call(line, pc, $urandom % 4, bsr_first ? OP_BSR : OP_JSR);
			fetch(line, pc, 3'd0, 1'b0, 1'b0, 1'b0, '0, ($urandom % 4) == 0);
		end

		repeat (3)
			fetch(rand_line(), 16'($urandom) & 16'hFFFC, 3'd0, 1'b0, 1'b0, 1'b0, '0, 1'b0);
		@(negedge clk);
		#1;

		$display("Errors: %0d from the model compare, %0d from assertions", errors,
			DUT.u_checker.fail_count);
		if (errors + DUT.u_checker.fail_count == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule
